// ==== design/pix_pkg.sv ====
`default_nettype none

package pix_pkg;

    // ==========================================================================
    // Sizes
    // ==========================================================================
    localparam int IMAGE_SIZE       = 16;
    localparam int BLOCK_COUNT      = 8;
    localparam int FIFO_DEPTH       = 8;
    localparam int REFRESH_INTERVAL = 16;
    localparam int REFRESH_CYCLES   = 2;

    // ==========================================================================
    // Word types
    // ==========================================================================
    typedef logic [11:0] pix_t;
    typedef logic [15:0] word_t;
    typedef logic [2:0]  block_t;
    typedef logic [3:0]  addr_t;

    // Host command, as seen on the top-level cmd port
    typedef enum logic [1:0] {CMD_NONE, CMD_CAPTURE, CMD_READOUT, CMD_STOP} cmd_e;

    // Command strobe from the controller to the frame store
    typedef enum logic [1:0] {STORE_NONE, STORE_WRITE, STORE_READ, STORE_STOP} store_cmd_e;

    // State machines
    typedef enum logic {CTRL_IDLE, CTRL_COPY} ctrl_state_e;
    typedef enum logic [1:0] {
        CAP_IDLE, CAP_WAIT_INVALID, CAP_WAIT_VALID, CAP_IN_FRAME
    } capture_state_e;
    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_FETCH, ST_OFFER} store_state_e;

endpackage

`default_nettype wire

// ==== design/frame_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface frame_port_if import pix_pkg::*; ();

    // Command strobe and target block
    store_cmd_e store_cmd;
    block_t     store_block;

    // Write stream, controller to store
    logic       write_ready;
    logic       write_trigger;
    word_t      write_data;
    logic       write_done;

    // Read stream, store to controller
    logic       read_ready;
    logic       read_trigger;
    word_t      read_data;
    logic       read_done;

    modport controller (
        output store_cmd, store_block, write_trigger, write_data, read_trigger,
        input  write_ready, write_done, read_ready, read_data, read_done
    );

    modport store (
        input  store_cmd, store_block, write_trigger, write_data, read_trigger,
        output write_ready, write_done, read_ready, read_data, read_done
    );

endinterface

`default_nettype wire

// ==== design/pix_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_fifo import pix_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  clear,
    input  logic  wr_en,
    input  word_t wr_data,
    output logic  full,
    input  logic  rd_en,
    output word_t rd_data,
    output logic  empty
);

    word_t mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;

    logic do_wr;
    logic do_rd;

    assign full  = (count == FIFO_DEPTH);
    assign empty = (count == 0);

    // Writes into a full FIFO are lost
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry is always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/pix_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_capture import pix_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  pix_t  pix_d,
    input  logic  pix_fv,
    input  logic  pix_lv,
    output logic  fifo_clear,
    output logic  fifo_wr_en,
    output word_t fifo_wr_data
);

    capture_state_e state;

    pix_t pix_d_q;
    logic pix_fv_q;
    logic pix_lv_q;

    logic frame_active;

    // ==========================================================================
    // Camera sampling
    // ==========================================================================
    always_ff @(posedge clk) begin
        pix_d_q <= pix_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_fv_q <= 1'b0;
            pix_lv_q <= 1'b0;
        end else begin
            pix_fv_q <= pix_fv;
            pix_lv_q <= pix_lv;
        end
    end

    // Old contents are dropped as soon as a capture starts
    assign fifo_clear = start;

    // The first fv-high sample already belongs to the frame
    assign frame_active = pix_fv_q && ((state == CAP_WAIT_VALID) || (state == CAP_IN_FRAME));

    // ==========================================================================
    // Frame sync FSM
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= CAP_IDLE;
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= frame_active && pix_lv_q;
            case (state)
                // Never join a frame that is already running
                CAP_WAIT_INVALID: begin
                    if (!pix_fv_q) begin
                        state <= CAP_WAIT_VALID;
                    end
                end
                CAP_WAIT_VALID: begin
                    if (pix_fv_q) begin
                        state <= CAP_IN_FRAME;
                    end
                end
                CAP_IN_FRAME: begin
                    if (!pix_fv_q) begin
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
            if (start) begin
                state      <= CAP_WAIT_INVALID;
                fifo_wr_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        fifo_wr_data <= word_t'(pix_d_q);
    end

endmodule

`default_nettype wire

// ==== design/frame_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_store import pix_pkg::*; (
    input logic         clk,
    input logic         rst,
    frame_port_if.store port
);

    word_t mem [BLOCK_COUNT][IMAGE_SIZE];

    store_state_e state;
    block_t       block_q;
    addr_t        addr;

    logic [$clog2(REFRESH_INTERVAL)-1:0] refresh_cnt;

    logic write_accept;
    logic last_word;

    // ==========================================================================
    // Stream handshakes
    // ==========================================================================

    // Refresh takes the tail of every interval
    assign port.write_ready = (state == ST_WRITE)
                              && (refresh_cnt < REFRESH_INTERVAL - REFRESH_CYCLES);

    assign write_accept    = port.write_trigger && port.write_ready;
    assign last_word       = (addr == addr_t'(IMAGE_SIZE - 1));
    assign port.write_done = write_accept && last_word;
    assign port.read_ready = (state == ST_OFFER);

    // ==========================================================================
    // Memory
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (write_accept) begin
            mem[block_q][addr] <= port.write_data;
        end
        // Prefetch the word to be offered next
        if (state == ST_FETCH) begin
            port.read_data <= mem[block_q][addr];
        end
    end

    always_ff @(posedge clk) begin
        if ((port.store_cmd == STORE_WRITE) || (port.store_cmd == STORE_READ)) begin
            block_q <= port.store_block;
        end
    end

    // ==========================================================================
    // Mode control
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            addr           <= '0;
            refresh_cnt    <= '0;
            port.read_done <= 1'b0;
        end else begin
            port.read_done <= 1'b0;

            case (state)
                ST_WRITE: begin
                    if (refresh_cnt == REFRESH_INTERVAL - 1) begin
                        refresh_cnt <= '0;
                    end else begin
                        refresh_cnt <= refresh_cnt + 1'b1;
                    end
                    if (write_accept) begin
                        addr <= addr + 1'b1;
                        if (last_word) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_FETCH: begin
                    state <= ST_OFFER;
                end
                ST_OFFER: begin
                    if (port.read_trigger) begin
                        if (last_word) begin
                            port.read_done <= 1'b1;
                            state          <= ST_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= ST_FETCH;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // Any command aborts the current transfer without a done pulse
            case (port.store_cmd)
                STORE_WRITE: begin
                    addr           <= '0;
                    refresh_cnt    <= '0;
                    port.read_done <= 1'b0;
                    state          <= ST_WRITE;
                end
                STORE_READ: begin
                    addr           <= '0;
                    port.read_done <= 1'b0;
                    state          <= ST_FETCH;
                end
                STORE_STOP: begin
                    port.read_done <= 1'b0;
                    state          <= ST_IDLE;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/pix_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_controller import pix_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  cmd_e                    cmd,
    input  block_t                  cmd_block,
    output logic                    capture_start,
    output logic                    fifo_rd_en,
    input  word_t                   fifo_rd_data,
    input  logic                    fifo_empty,
    frame_port_if.controller        store,
    output logic                    capture_done,
    output logic                    readout_ready,
    input  logic                    readout_trigger,
    output word_t                   readout_data,
    output logic                    readout_done
);

    ctrl_state_e state;

    logic write_accept;

    // ==========================================================================
    // Readout path
    // ==========================================================================
    assign readout_ready      = store.read_ready;
    assign readout_data       = store.read_data;
    assign readout_done       = store.read_done;
    assign store.read_trigger = readout_trigger;

    // ==========================================================================
    // FIFO to frame store copy
    // ==========================================================================
    assign write_accept = store.write_trigger && store.write_ready;

    // Pop while the holding register is free or draining this cycle.
    // Nothing is popped while the FIFO is being cleared.
    assign fifo_rd_en = (state == CTRL_COPY) && !capture_start && !fifo_empty
                        && (!store.write_trigger || store.write_ready);

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            store.write_data <= fifo_rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd != CMD_NONE) begin
            store.store_block <= cmd_block;
        end
    end

    // ==========================================================================
    // Command FSM
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= CTRL_IDLE;
            store.store_cmd     <= STORE_NONE;
            store.write_trigger <= 1'b0;
            capture_start       <= 1'b0;
            capture_done        <= 1'b0;
        end else begin
            store.store_cmd <= STORE_NONE;
            capture_start   <= 1'b0;
            capture_done    <= 1'b0;

            if (state == CTRL_COPY) begin
                if (write_accept) begin
                    store.write_trigger <= 1'b0;
                end
                if (fifo_rd_en) begin
                    store.write_trigger <= 1'b1;
                end
                // Store counts the words, so its done ends the capture
                if (store.write_done) begin
                    store.write_trigger <= 1'b0;
                    capture_done        <= 1'b1;
                    state               <= CTRL_IDLE;
                end
            end

            // New command wins over whatever is in progress
            case (cmd)
                CMD_CAPTURE: begin
                    store.store_cmd     <= STORE_WRITE;
                    store.write_trigger <= 1'b0;
                    capture_start       <= 1'b1;
                    capture_done        <= 1'b0;
                    state               <= CTRL_COPY;
                end
                CMD_READOUT: begin
                    store.store_cmd     <= STORE_READ;
                    store.write_trigger <= 1'b0;
                    capture_done        <= 1'b0;
                    state               <= CTRL_IDLE;
                end
                CMD_STOP: begin
                    store.store_cmd     <= STORE_STOP;
                    store.write_trigger <= 1'b0;
                    capture_done        <= 1'b0;
                    state               <= CTRL_IDLE;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/pix_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_top import pix_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  cmd_e   cmd,
    input  block_t cmd_block,
    input  pix_t   pix_d,
    input  logic   pix_fv,
    input  logic   pix_lv,
    input  logic   readout_trigger,
    output logic   capture_done,
    output logic   readout_ready,
    output word_t  readout_data,
    output logic   readout_done
);

    logic  capture_start;
    logic  fifo_clear;
    logic  fifo_wr_en;
    word_t fifo_wr_data;
    logic  fifo_rd_en;
    word_t fifo_rd_data;
    logic  fifo_empty;

    frame_port_if port_if ();

    // ==========================================================================
    // Capture path
    // ==========================================================================
    pix_capture u_capture (
        .clk          (clk),
        .rst          (rst),
        .start        (capture_start),
        .pix_d        (pix_d),
        .pix_fv       (pix_fv),
        .pix_lv       (pix_lv),
        .fifo_clear   (fifo_clear),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data)
    );

    pix_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .clear   (fifo_clear),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .full    (),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    // ==========================================================================
    // Control and storage
    // ==========================================================================
    pix_controller u_controller (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .capture_start   (capture_start),
        .fifo_rd_en      (fifo_rd_en),
        .fifo_rd_data    (fifo_rd_data),
        .fifo_empty      (fifo_empty),
        .store           (port_if.controller),
        .capture_done    (capture_done),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .readout_done    (readout_done)
    );

    frame_store u_store (
        .clk  (clk),
        .rst  (rst),
        .port (port_if.store)
    );

endmodule

`default_nettype wire

// ==== testbench/pix_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_checker import pix_pkg::*; (
    input logic   clk,
    input logic   rst,
    input cmd_e   cmd,
    input block_t cmd_block,
    input pix_t   pix_d,
    input logic   pix_fv,
    input logic   pix_lv,
    input logic   readout_trigger,
    input logic   capture_done,
    input logic   readout_ready,
    input word_t  readout_data,
    input logic   readout_done
);

    word_t model [BLOCK_COUNT][IMAGE_SIZE];

    capture_state_e cap_state;
    logic           cap_pending;
    block_t         cap_block;
    int             cap_count;

    // Commands reach the frame store two cycles after the host
    cmd_e   cmd_q1;
    cmd_e   cmd_q2;
    block_t blk_q1;
    block_t blk_q2;

    logic   rd_active;
    block_t rd_block;
    int     rd_idx;
    logic   held;
    word_t  held_data;

    int    exp_cap;
    int    act_cap;
    int    exp_rd;
    int    act_rd;
    int    errors = 0;
    int    test_errors = 0;
    int    passed = 0;
    int    failed = 0;
    string test_name = "";

    task note_error;
        errors++;
        test_errors++;
    endtask

    task report_value(input string what, input word_t expected, input word_t actual);
        $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
        note_error();
    endtask

    task check_pulses(input string sig, input int expected, input int seen);
        if (seen < expected) begin
            $display("%s: missing %s pulse, expected %0d and saw %0d",
                     test_name, sig, expected, seen);
            note_error();
        end else if (seen > expected) begin
            $display("%s: extra %s pulse, expected %0d and saw %0d",
                     test_name, sig, expected, seen);
            note_error();
        end
    endtask

    task begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        exp_cap     = 0;
        act_cap     = 0;
        exp_rd      = 0;
        act_rd      = 0;
    endtask

    task end_test;
        check_pulses("capture_done", exp_cap, act_cap);
        check_pulses("readout_done", exp_rd, act_rd);
        if (test_errors == 0) begin
            passed++;
            $display("PASS %s", test_name);
        end else begin
            failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
    endtask

    // Only lv-high samples of the frame go in, and only the first IMAGE_SIZE
    task keep_pixel;
        if (pix_lv && cap_count < IMAGE_SIZE) begin
            model[cap_block][cap_count] = word_t'(pix_d);
            cap_count++;
            if (cap_count == IMAGE_SIZE) begin
                exp_cap++;
            end
        end
    endtask

    // ========================================================================
    // Frame model from the camera port
    // ========================================================================
    always @(posedge clk) begin
        if (rst) begin
            cap_state   = CAP_IDLE;
            cap_pending = 1'b0;
            cap_count   = 0;
            rd_active   = 1'b0;
            held        = 1'b0;
            cmd_q1      = CMD_NONE;
            cmd_q2      = CMD_NONE;
        end else begin
            // The capture FSM starts on the sample after the command
            if (cap_pending) begin
                cap_state   = CAP_WAIT_INVALID;
                cap_count   = 0;
                cap_pending = 1'b0;
            end
            case (cap_state)
                CAP_WAIT_INVALID: begin
                    if (!pix_fv) begin
                        cap_state = CAP_WAIT_VALID;
                    end
                end
                CAP_WAIT_VALID: begin
                    if (pix_fv) begin
                        cap_state = CAP_IN_FRAME;
                        keep_pixel();
                    end
                end
                CAP_IN_FRAME: begin
                    if (pix_fv) begin
                        keep_pixel();
                    end else begin
                        cap_state = CAP_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // ================================================================
            // Readout stream
            // ================================================================
            if (cmd_q2 != CMD_NONE) begin
                rd_active = (cmd_q2 == CMD_READOUT);
                rd_block  = blk_q2;
                rd_idx    = 0;
                held      = 1'b0;
            end else if (readout_ready && !rd_active) begin
                $display("%s: readout_ready high with no readout in progress", test_name);
                note_error();
            end else if (readout_ready) begin
                if (held && readout_data !== held_data) begin
                    report_value("held word", held_data, readout_data);
                end
                if (readout_trigger) begin
                    report_if_wrong();
                    held = 1'b0;
                    if (rd_idx == IMAGE_SIZE - 1) begin
                        exp_rd++;
                        rd_active = 1'b0;
                    end else begin
                        rd_idx++;
                    end
                end else begin
                    held      = 1'b1;
                    held_data = readout_data;
                end
            end else begin
                held = 1'b0;
            end

            if (capture_done) begin
                act_cap++;
            end
            if (readout_done) begin
                act_rd++;
            end

            cmd_q2 = cmd_q1;
            blk_q2 = blk_q1;
            cmd_q1 = cmd;
            blk_q1 = cmd_block;
            if (cmd == CMD_CAPTURE) begin
                cap_pending = 1'b1;
                cap_block   = cmd_block;
            end
        end
    end

    task report_if_wrong;
        string what;
        what = $sformatf("word %0d", rd_idx);
        if (readout_data !== model[rd_block][rd_idx]) begin
            report_value(what, model[rd_block][rd_idx], readout_data);
        end
    endtask

endmodule

`default_nettype wire

// ==== testbench/pix_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pix_tb import pix_pkg::*; ();

    logic   clk;
    logic   rst;
    cmd_e   cmd;
    block_t cmd_block;
    pix_t   pix_d;
    logic   pix_fv;
    logic   pix_lv;
    logic   readout_trigger;
    logic   capture_done;
    logic   readout_ready;
    word_t  readout_data;
    logic   readout_done;

    logic [15:0] lfsr_state;
    logic        cap_seen;
    logic        rd_seen;
    int          cycles = 0;
    int          cycle_limit = 0;

    // Stimulus table, one entry per test
    string row_name [$];
    cmd_e  row_cmd [$];
    int    row_block [$];
    int    row_lines [$];
    int    row_ppl [$];
    int    row_gap [$];
    int    row_mid [$];
    int    row_cut [$];
    int    row_stall [$];

    pix_top dut (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .readout_trigger (readout_trigger),
        .capture_done    (capture_done),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_done    (readout_done)
    );

    pix_checker chk (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .readout_trigger (readout_trigger),
        .capture_done    (capture_done),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_done    (readout_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (capture_done) begin
            cap_seen = 1'b1;
        end
        if (readout_done) begin
            rd_seen = 1'b1;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            value = {value[14:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    task automatic add_row(input string name, input cmd_e c, input int blk, input int lines,
                           input int ppl, input int gap, input int mid, input int cut,
                           input int stall);
        row_name.push_back(name);
        row_cmd.push_back(c);
        row_block.push_back(blk);
        row_lines.push_back(lines);
        row_ppl.push_back(ppl);
        row_gap.push_back(gap);
        row_mid.push_back(mid);
        row_cut.push_back(cut);
        row_stall.push_back(stall);
    endtask

    // ========================================================================
    // Camera and host drivers
    // ========================================================================

    // One pixel clock; pix_d is random on every cycle, lv or not
    task automatic camera_cycle(input logic fv, input logic lv);
        pix_fv = fv;
        pix_lv = lv;
        pix_d  = pix_t'(rand_bits(12));
        @(negedge clk);
        cmd = CMD_NONE;
    endtask

    task automatic camera_line(input int ppl, input int gap);
        repeat (gap) camera_cycle(1'b1, 1'b0);
        repeat (ppl) camera_cycle(1'b1, 1'b1);
    endtask

    task automatic camera_frame(input int lines, input int ppl, input int gap);
        repeat (lines) camera_line(ppl, gap);
        repeat (gap) camera_cycle(1'b1, 1'b0);
        repeat (gap) camera_cycle(1'b0, 1'b0);
    endtask

    task automatic run_capture(input int i);
        if (row_mid[i] != 0) begin
            // Frame already running when the command arrives
            camera_line(row_ppl[i], row_gap[i]);
            cmd       = CMD_CAPTURE;
            cmd_block = block_t'(row_block[i]);
            camera_cycle(1'b1, 1'b0);
            camera_line(row_ppl[i], row_gap[i]);
            repeat (row_gap[i]) camera_cycle(1'b0, 1'b0);
        end else begin
            cmd       = CMD_CAPTURE;
            cmd_block = block_t'(row_block[i]);
            camera_cycle(1'b0, 1'b0);
            repeat (row_gap[i]) camera_cycle(1'b0, 1'b0);
        end
        camera_frame(row_lines[i], row_ppl[i], row_gap[i]);
        while (!cap_seen) @(negedge clk);
    endtask

    task automatic read_words(input int count, input int stall);
        int taken;
        int gap;
        taken = 0;
        while (taken < count) begin
            gap = (stall == 0) ? 0 : int'(rand_bits(3)) % (stall + 1);
            readout_trigger = 1'b0;
            repeat (gap) @(negedge clk);
            readout_trigger = 1'b1;
            while (!readout_ready) @(negedge clk);
            taken++;
            @(negedge clk);
        end
        readout_trigger = 1'b0;
    endtask

    task automatic run_readout(input int i);
        cmd       = CMD_READOUT;
        cmd_block = block_t'(row_block[i]);
        @(negedge clk);
        cmd = CMD_NONE;
        if (row_cut[i] != 0) begin
            read_words(row_cut[i], row_stall[i]);
            cmd = CMD_STOP;
            @(negedge clk);
            cmd = CMD_NONE;
        end else begin
            read_words(IMAGE_SIZE, row_stall[i]);
            while (!rd_seen) @(negedge clk);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int i;
        int frame;
        rst             = 1'b1;
        cmd             = CMD_NONE;
        cmd_block       = '0;
        pix_d           = '0;
        pix_fv          = 1'b0;
        pix_lv          = 1'b0;
        readout_trigger = 1'b0;
        cap_seen        = 1'b0;
        rd_seen         = 1'b0;
        lfsr_state      = 16'd54;

        //      name               cmd          blk lines ppl gap mid cut stall
        add_row("cap_b3",          CMD_CAPTURE, 3,  4,    4,  2,  0,  0,  0);
        add_row("read_b3",         CMD_READOUT, 3,  0,    0,  0,  0,  0,  0);
        add_row("cap_b3_midframe", CMD_CAPTURE, 3,  3,    6,  3,  1,  0,  0);
        add_row("read_b3_again",   CMD_READOUT, 3,  0,    0,  0,  0,  0,  0);
        add_row("cap_b2",          CMD_CAPTURE, 2,  5,    5,  2,  0,  0,  0);
        add_row("cap_b5",          CMD_CAPTURE, 5,  3,    6,  3,  0,  0,  0);
        add_row("read_b2_stall",   CMD_READOUT, 2,  0,    0,  0,  0,  0,  7);
        add_row("read_b5_stall",   CMD_READOUT, 5,  0,    0,  0,  0,  0,  5);
        add_row("read_b5_stop",    CMD_READOUT, 5,  0,    0,  0,  0,  6,  3);
        add_row("read_b5_restart", CMD_READOUT, 5,  0,    0,  0,  0,  0,  2);

        for (i = 0; i < row_name.size(); i++) begin
            frame = row_lines[i] * (row_ppl[i] + row_gap[i]) + 3 * row_gap[i] + 20;
            if (row_cmd[i] == CMD_CAPTURE) begin
                cycle_limit += (row_mid[i] + 1) * frame;
            end else begin
                cycle_limit += IMAGE_SIZE * (row_stall[i] + 3) + 20;
            end
        end
        cycle_limit = 2 * cycle_limit + 100;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < row_name.size(); i++) begin
            @(negedge clk);
            chk.begin_test(row_name[i]);
            cap_seen = 1'b0;
            rd_seen  = 1'b0;
            if (row_cmd[i] == CMD_CAPTURE) begin
                run_capture(i);
            end else begin
                run_readout(i);
            end
            repeat (4) @(negedge clk);
            chk.end_test();
        end

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 chk.passed, chk.failed, chk.errors);
        if (chk.failed == 0 && chk.errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run exceeded its limit of %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/pix_pkg.sv
design/frame_port_if.sv
design/pix_fifo.sv
design/pix_capture.sv
design/frame_store.sv
design/pix_controller.sv
design/pix_top.sv
testbench/pix_checker.sv
testbench/pix_tb.sv
